/* project.f */
source/core_pkg.sv
source/la_axi_bus.sv
source/mem_req_if.sv
source/reg_file.sv
source/core_exec.sv
source/axi_master.sv
source/core_top.sv
sim/tb_clock.sv
sim/axi_ram.sv
sim/tb_core_top.sv

/* run.sh */
#!/bin/sh
# build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_core_top -f project.f
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_core_top 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "ALL TESTS PASSED"; then
  exit 0
fi
exit 1

/* sim/tb_core_top.sv */
`timescale 1ns/1ps

module tb_core_top;
  import core_pkg::*;

  localparam int n_inst = 120;
  localparam int cycle_limit = 8 + n_inst * 40;

  logic        aclk;
  logic        reset;
  logic [3:0]  arid;
  logic [31:0] araddr;
  logic [7:0]  arlen;
  logic [2:0]  arsize;
  logic [1:0]  arburst;
  logic [1:0]  arlock;
  logic [3:0]  arcache;
  logic [2:0]  arprot;
  logic        arvalid;
  logic        arready;
  logic [3:0]  rid;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rlast;
  logic        rvalid;
  logic        rready;
  logic [3:0]  awid;
  logic [31:0] awaddr;
  logic [7:0]  awlen;
  logic [2:0]  awsize;
  logic [1:0]  awburst;
  logic [1:0]  awlock;
  logic [3:0]  awcache;
  logic [2:0]  awprot;
  logic        awvalid;
  logic        awready;
  logic [3:0]  wid;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        wlast;
  logic        wvalid;
  logic        wready;
  logic [3:0]  bid;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        bready;
  logic [31:0] debug0_wb_pc;
  logic [3:0]  debug0_wb_rf_wen;
  logic [4:0]  debug0_wb_rf_wnum;
  logic [31:0] debug0_wb_rf_wdata;
  logic [31:0] debug0_wb_inst;

  integer      seed;
  logic [31:0] prog [n_inst];
  // reference model state
  logic [31:0] m_regs [32];
  logic [31:0] m_data [64];
  int          mi;
  int          value_errors;
  int          other_errors;
  int          cycle;
  int          reset_cycles;
  int          fetch_count;
  logic        done;
  logic        timed_out;
  logic        first_ar_done;
  // store currently crossing aw/w
  logic        st_open;
  logic        st_aw_seen;
  logic        st_w_seen;
  // read or write waiting for its response
  logic        rd_open;
  logic        wr_open;
  int          ev_kind;
  logic [4:0]  ev_wnum;
  logic [31:0] ev_val;
  logic [31:0] ev_addr;
  logic [31:0] ev_pc;
  logic [31:0] ev_inst;
  logic        prev_arvalid;
  logic        prev_arready;
  logic [31:0] prev_araddr;
  logic [3:0]  prev_arid;
  logic        prev_awvalid;
  logic        prev_awready;
  logic [31:0] prev_awaddr;
  logic [3:0]  prev_awid;
  logic        prev_wvalid;
  logic        prev_wready;
  logic [31:0] prev_wdata;

  tb_clock clk0 (.aclk(aclk));

  axi_ram ram0 (.*);

  core_top dut0 (.*);

  function automatic logic [31:0] enc_ri12(input logic [9:0] op, input logic [11:0] imm,
                                           input logic [4:0] rj, input logic [4:0] rd);
    return {op, imm, rj, rd};
  endfunction

  function automatic logic [31:0] enc_r3(input logic [4:0] rk, input logic [4:0] rj,
                                         input logic [4:0] rd);
    return {op_add_w, rk, rj, rd};
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("Error %s expected %h actual %h", name, exp, act);
    value_errors = value_errors + 1;
  endtask

  // single beat word attributes on an address handshake
  task automatic check_attrs(input string ch, input logic [7:0] len, input logic [2:0] size,
                             input logic [1:0] burst, input logic [1:0] lock,
                             input logic [3:0] cache, input logic [2:0] prot);
    if (len != 8'd0) begin
      report_mismatch({ch, "len"}, 32'h0, 32'(len));
    end
    if (size != axi_size_word) begin
      report_mismatch({ch, "size"}, 32'(axi_size_word), 32'(size));
    end
    if (burst != axi_burst_incr) begin
      report_mismatch({ch, "burst"}, 32'(axi_burst_incr), 32'(burst));
    end
    if (lock != axi_lock_normal) begin
      report_mismatch({ch, "lock"}, 32'(axi_lock_normal), 32'(lock));
    end
    if (cache != axi_cache_none) begin
      report_mismatch({ch, "cache"}, 32'(axi_cache_none), 32'(cache));
    end
    if (prot != axi_prot_data) begin
      report_mismatch({ch, "prot"}, 32'(axi_prot_data), 32'(prot));
    end
  endtask

  // random destination that never touches the r1 data base
  function automatic logic [4:0] pick_rd();
    logic [31:0] r;
    r = $random(seed);
    if (r[4:0] == 5'd1) begin
      return 5'd0;
    end
    return r[4:0];
  endfunction

  task automatic build_program();
    logic [31:0] r;
    logic [31:0] a;
    logic [31:0] b;
    int          n;
    // r1 = 0x1c1 doubled 20 times gives 0x1c100000
    prog[0] = enc_ri12(op_addi_w, 12'h1c1, 5'd0, 5'd1);
    for (int i = 1; i <= 20; i++) begin
      prog[i] = enc_r3(5'd1, 5'd1, 5'd1);
    end
    n = 21;
    // defined start values for r2..r31
    for (int k = 2; k < 32; k++) begin
      r = $random(seed);
      prog[n] = enc_ri12(op_addi_w, r[11:0], 5'd0, 5'(k));
      n = n + 1;
    end
    while (n < n_inst) begin
      r = $random(seed);
      a = $random(seed);
      b = $random(seed);
      case (r[1:0])
        2'd0: prog[n] = enc_ri12(op_addi_w, a[11:0], b[4:0], pick_rd());
        2'd1: prog[n] = enc_r3(a[4:0], b[4:0], pick_rd());
        2'd2: prog[n] = enc_ri12(op_ld_w, {4'h0, a[5:0], 2'b00}, 5'd1, pick_rd());
        default: prog[n] = enc_ri12(op_st_w, {4'h0, a[5:0], 2'b00}, 5'd1, b[4:0]);
      endcase
      n = n + 1;
    end
  endtask

  // ISA model that runs up to the next observable instruction
  // kind 1 is a register write, kind 2 a store, 0 means none left
  task automatic next_event();
    inst_t       word;
    logic [31:0] imm;
    logic [31:0] a;
    logic [31:0] res;
    logic        wr;
    ev_kind = 0;
    while (ev_kind == 0 && mi < n_inst) begin
      word    = prog[mi];
      ev_pc   = reset_pc + (mi << 2);
      ev_inst = word;
      imm     = {{20{word.ri12.imm[11]}}, word.ri12.imm};
      a       = m_regs[word.ri12.rj] + imm;
      wr      = 1'b0;
      res     = 32'h0;
      if (word.r3.opcode == op_add_w) begin
        res = m_regs[word.r3.rj] + m_regs[word.r3.rk];
        wr  = 1'b1;
      end else if (word.ri12.opcode == op_addi_w) begin
        res = a;
        wr  = 1'b1;
      end else if (word.ri12.opcode == op_ld_w) begin
        res = m_data[a[7:2]];
        wr  = 1'b1;
      end else if (word.ri12.opcode == op_st_w) begin
        ev_kind = 2;
        ev_addr = a;
        ev_val  = m_regs[word.ri12.rd];
        m_data[a[7:2]] = m_regs[word.ri12.rd];
      end
      if (wr && word.ri12.rd != 5'd0) begin
        m_regs[word.ri12.rd] = res;
        ev_kind = 1;
        ev_wnum = word.ri12.rd;
        ev_val  = res;
      end
      mi = mi + 1;
    end
  endtask

  initial begin
    seed          = 45005;
    reset         = 1'b1;
    mi            = 0;
    value_errors  = 0;
    other_errors  = 0;
    cycle         = 0;
    reset_cycles  = 0;
    fetch_count   = 0;
    done          = 1'b0;
    timed_out     = 1'b0;
    first_ar_done = 1'b0;
    st_open       = 1'b0;
    st_aw_seen    = 1'b0;
    st_w_seen     = 1'b0;
    rd_open       = 1'b0;
    wr_open       = 1'b0;
    prev_arvalid  = 1'b0;
    prev_awvalid  = 1'b0;
    prev_wvalid   = 1'b0;
    for (int i = 0; i < 32; i++) begin
      m_regs[i] = 32'h0;
    end
    for (int i = 0; i < 64; i++) begin
      m_data[i] = 32'h0;
    end
    build_program();
    for (int i = 0; i < 256; i++) begin
      ram0.prog_mem[i] = (i < n_inst) ? prog[i] : 32'h0;
    end
    repeat (8) @(posedge aclk);
    #1 reset = 1'b0;
    while (!done && cycle < cycle_limit) begin
      @(posedge aclk);
    end
    #2;
    if (!done) begin
      $display("timeout: core stalled after %0d fetches", fetch_count);
      timed_out = 1'b1;
    end else begin
      // whatever is left must have no visible effect
      while (mi < n_inst) begin
        next_event();
        if (ev_kind != 0) begin
          $display("instruction at %h retired without its expected event", ev_pc);
          other_errors = other_errors + 1;
        end
      end
    end
    $display("value errors %0d, other errors %0d", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0 && !timed_out) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // monitor sees pre-edge values at each rising edge
  always @(posedge aclk) begin
    cycle = cycle + 1;
    if (reset) begin
      reset_cycles = reset_cycles + 1;
      if (reset_cycles > 2 && (arvalid || awvalid || wvalid || rready || bready ||
                               debug0_wb_rf_wen != 4'h0)) begin
        $display("valid, ready or writeback raised during reset");
        other_errors = other_errors + 1;
      end
    end else if (!done) begin
      if (!first_ar_done && (awvalid || wvalid || debug0_wb_rf_wen != 4'h0)) begin
        $display("write or writeback before the first fetch");
        other_errors = other_errors + 1;
      end
      // valids hold with stable fields until ready
      if (prev_arvalid && !prev_arready) begin
        if (!arvalid || araddr != prev_araddr || arid != prev_arid) begin
          $display("ar channel changed before arready");
          other_errors = other_errors + 1;
        end
      end
      if (prev_awvalid && !prev_awready) begin
        if (!awvalid || awaddr != prev_awaddr || awid != prev_awid) begin
          $display("aw channel changed before awready");
          other_errors = other_errors + 1;
        end
      end
      if (prev_wvalid && !prev_wready) begin
        if (!wvalid || wdata != prev_wdata) begin
          $display("w channel changed before wready");
          other_errors = other_errors + 1;
        end
      end
      // response ready only while that response is awaited
      if (rready && !rd_open) begin
        $display("rready raised with no read outstanding");
        other_errors = other_errors + 1;
      end
      if (bready && !wr_open) begin
        $display("bready raised with no write outstanding");
        other_errors = other_errors + 1;
      end
      if (rvalid && rready) begin
        rd_open = 1'b0;
      end
      if (bvalid && bready) begin
        wr_open = 1'b0;
      end
      if (arvalid && arready) begin
        rd_open = 1'b1;
        check_attrs("ar", arlen, arsize, arburst, arlock, arcache, arprot);
        if (!first_ar_done && arid != axi_id_fetch) begin
          report_mismatch("first_arid", 32'(axi_id_fetch), 32'(arid));
        end
        first_ar_done = 1'b1;
        if (arid == axi_id_fetch) begin
          if (araddr != reset_pc + (fetch_count << 2)) begin
            report_mismatch("fetch_addr", reset_pc + (fetch_count << 2), araddr);
          end
          fetch_count = fetch_count + 1;
          // fetch past the last one means all retired
          if (fetch_count > n_inst) begin
            done = 1'b1;
          end
        end
      end
      if (debug0_wb_rf_wen != 4'h0) begin
        next_event();
        if (ev_kind != 1) begin
          $display("trace pulse with no matching register write");
          other_errors = other_errors + 1;
        end else begin
          if (debug0_wb_rf_wen != 4'hf) begin
            report_mismatch("trace_wen", 32'hf, 32'(debug0_wb_rf_wen));
          end
          if (debug0_wb_pc != ev_pc) begin
            report_mismatch("trace_pc", ev_pc, debug0_wb_pc);
          end
          if (debug0_wb_inst != ev_inst) begin
            report_mismatch("trace_inst", ev_inst, debug0_wb_inst);
          end
          if (debug0_wb_rf_wnum != ev_wnum) begin
            report_mismatch("trace_wnum", 32'(ev_wnum), 32'(debug0_wb_rf_wnum));
          end
          if (debug0_wb_rf_wdata != ev_val) begin
            report_mismatch("trace_wdata", ev_val, debug0_wb_rf_wdata);
          end
        end
      end
      // aw and w of a store may be accepted in either order
      if ((awvalid && awready) || (wvalid && wready)) begin
        if (!st_open) begin
          next_event();
          st_open = 1'b1;
          if (ev_kind != 2) begin
            $display("AXI write with no matching store");
            other_errors = other_errors + 1;
          end
        end
      end
      if (awvalid && awready) begin
        st_aw_seen = 1'b1;
        check_attrs("aw", awlen, awsize, awburst, awlock, awcache, awprot);
        if (awaddr != ev_addr) begin
          report_mismatch("store_awaddr", ev_addr, awaddr);
        end
        if (awid != axi_id_data) begin
          report_mismatch("store_awid", 32'(axi_id_data), 32'(awid));
        end
      end
      if (wvalid && wready) begin
        st_w_seen = 1'b1;
        if (wdata != ev_val) begin
          report_mismatch("store_wdata", ev_val, wdata);
        end
        if (wstrb != 4'hf) begin
          report_mismatch("store_wstrb", 32'hf, 32'(wstrb));
        end
        if (wid != axi_id_data) begin
          report_mismatch("store_wid", 32'(axi_id_data), 32'(wid));
        end
        if (!wlast) begin
          report_mismatch("store_wlast", 32'h1, 32'h0);
        end
      end
      if (st_aw_seen && st_w_seen) begin
        st_open    = 1'b0;
        st_aw_seen = 1'b0;
        st_w_seen  = 1'b0;
        wr_open    = 1'b1;
      end
    end
    prev_arvalid = arvalid;
    prev_arready = arready;
    prev_araddr  = araddr;
    prev_arid    = arid;
    prev_awvalid = awvalid;
    prev_awready = awready;
    prev_awaddr  = awaddr;
    prev_awid    = awid;
    prev_wvalid  = wvalid;
    prev_wready  = wready;
    prev_wdata   = wdata;
  end

endmodule

/* sim/axi_ram.sv */
`timescale 1ns/1ps

module axi_ram (
  input  logic        aclk,
  input  logic        reset,
  input  logic [3:0]  arid,
  input  logic [31:0] araddr,
  input  logic        arvalid,
  output logic        arready,
  output logic [3:0]  rid,
  output logic [31:0] rdata,
  output logic [1:0]  rresp,
  output logic        rlast,
  output logic        rvalid,
  input  logic        rready,
  input  logic [3:0]  awid,
  input  logic [31:0] awaddr,
  input  logic        awvalid,
  output logic        awready,
  input  logic [31:0] wdata,
  input  logic        wvalid,
  output logic        wready,
  output logic [3:0]  bid,
  output logic [1:0]  bresp,
  output logic        bvalid,
  input  logic        bready
);

  // program at 0x1c000000, data at 0x1c100000
  logic [31:0] prog_mem [256];
  logic [31:0] data_mem [64];
  integer      seed;
  logic        ar_hs;
  logic        r_hs;
  logic        aw_hs;
  logic        w_hs;
  logic        b_hs;
  logic        rd_pend;
  int          rd_wait;
  logic [3:0]  rd_id;
  logic [31:0] rd_addr;
  logic        aw_got;
  logic        w_got;
  int          wr_wait;
  logic [3:0]  wr_id;
  logic [31:0] wr_addr;
  logic [31:0] wr_data;

  function automatic logic [31:0] read_word(input logic [31:0] addr);
    if (addr[31:20] == 12'h1c1) begin
      return data_mem[addr[7:2]];
    end
    return prog_mem[addr[9:2]];
  endfunction

  initial begin
    seed = 45005;
    for (int i = 0; i < 64; i++) begin
      data_mem[i] = 32'h0;
    end
    arready = 1'b0;
    rvalid  = 1'b0;
    rid     = 4'h0;
    rdata   = 32'h0;
    awready = 1'b0;
    wready  = 1'b0;
    bvalid  = 1'b0;
    bid     = 4'h0;
    rd_pend = 1'b0;
    aw_got  = 1'b0;
    w_got   = 1'b0;
    rd_wait = 0;
    wr_wait = 0;
  end

  // single beat responses with okay status
  assign rresp = 2'd0;
  assign rlast = 1'b1;
  assign bresp = 2'd0;

  always @(posedge aclk) begin
    // handshakes completed at this edge
    ar_hs = arvalid && arready;
    r_hs  = rvalid && rready;
    aw_hs = awvalid && awready;
    w_hs  = wvalid && wready;
    b_hs  = bvalid && bready;
    if (ar_hs) begin
      rd_id   = arid;
      rd_addr = araddr;
      rd_pend = 1'b1;
      rd_wait = $random(seed) & 3;
    end
    if (aw_hs) begin
      wr_id   = awid;
      wr_addr = awaddr;
      aw_got  = 1'b1;
    end
    if (w_hs) begin
      wr_data = wdata;
      w_got   = 1'b1;
    end
    #1;
    if (reset) begin
      arready = 1'b0;
      rvalid  = 1'b0;
      awready = 1'b0;
      wready  = 1'b0;
      bvalid  = 1'b0;
      rd_pend = 1'b0;
      aw_got  = 1'b0;
      w_got   = 1'b0;
    end else begin
      if (r_hs) begin
        rvalid = 1'b0;
      end
      if (b_hs) begin
        bvalid = 1'b0;
      end
      // read data after a random gap
      if (rd_pend) begin
        if (rd_wait == 0) begin
          rvalid  = 1'b1;
          rid     = rd_id;
          rdata   = read_word(rd_addr);
          rd_pend = 1'b0;
        end else begin
          rd_wait = rd_wait - 1;
        end
      end
      // write lands once both aw and w are in
      if (aw_got && w_got) begin
        if (wr_wait == 0) begin
          if (wr_addr[31:20] == 12'h1c1) begin
            data_mem[wr_addr[7:2]] = wr_data;
          end
          bvalid  = 1'b1;
          bid     = wr_id;
          aw_got  = 1'b0;
          w_got   = 1'b0;
          wr_wait = $random(seed) & 3;
        end else begin
          wr_wait = wr_wait - 1;
        end
      end
      arready = !rd_pend && !rvalid && ($random(seed) & 1) != 0;
      awready = !aw_got && ($random(seed) & 1) != 0;
      wready  = !w_got && ($random(seed) & 1) != 0;
    end
  end

endmodule

/* sim/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
  output logic aclk
);

  // 8 ns period
  initial begin
    aclk = 1'b0;
  end

  always #4 aclk = ~aclk;

endmodule

/* source/core_top.sv */
`timescale 1ns/1ps

module core_top (
  input  logic                          aclk,
  input  logic                          reset,
  // read address
  output logic [core_pkg::axi_id_w-1:0] arid,
  output logic [core_pkg::xlen-1:0]     araddr,
  output logic [7:0]                    arlen,
  output logic [2:0]                    arsize,
  output logic [1:0]                    arburst,
  output logic [1:0]                    arlock,
  output logic [3:0]                    arcache,
  output logic [2:0]                    arprot,
  output logic                          arvalid,
  input  logic                          arready,
  // read data
  input  logic [core_pkg::axi_id_w-1:0] rid,
  input  logic [core_pkg::xlen-1:0]     rdata,
  input  logic [1:0]                    rresp,
  input  logic                          rlast,
  input  logic                          rvalid,
  output logic                          rready,
  // write address
  output logic [core_pkg::axi_id_w-1:0] awid,
  output logic [core_pkg::xlen-1:0]     awaddr,
  output logic [7:0]                    awlen,
  output logic [2:0]                    awsize,
  output logic [1:0]                    awburst,
  output logic [1:0]                    awlock,
  output logic [3:0]                    awcache,
  output logic [2:0]                    awprot,
  output logic                          awvalid,
  input  logic                          awready,
  // write data
  output logic [core_pkg::axi_id_w-1:0] wid,
  output logic [core_pkg::xlen-1:0]     wdata,
  output logic [3:0]                    wstrb,
  output logic                          wlast,
  output logic                          wvalid,
  input  logic                          wready,
  // write response
  input  logic [core_pkg::axi_id_w-1:0] bid,
  input  logic [1:0]                    bresp,
  input  logic                          bvalid,
  output logic                          bready,
  // writeback trace
  output logic [core_pkg::xlen-1:0]     debug0_wb_pc,
  output logic [3:0]                    debug0_wb_rf_wen,
  output logic [4:0]                    debug0_wb_rf_wnum,
  output logic [core_pkg::xlen-1:0]     debug0_wb_rf_wdata,
  output logic [core_pkg::xlen-1:0]     debug0_wb_inst
);
  import core_pkg::*;

  // core sees reset one cycle late
  logic reset_q;

  always_ff @(posedge aclk) begin
    reset_q <= reset;
  end

  la_axi_bus axi_bus ();
  mem_req_if mem_req ();

  // slave side inputs
  assign axi_bus.ar_ready = arready;
  assign axi_bus.r_id     = rid;
  assign axi_bus.r_data   = rdata;
  assign axi_bus.r_resp   = rresp;
  assign axi_bus.r_last   = rlast;
  assign axi_bus.r_valid  = rvalid;
  assign axi_bus.aw_ready = awready;
  assign axi_bus.w_ready  = wready;
  assign axi_bus.b_id     = bid;
  assign axi_bus.b_resp   = bresp;
  assign axi_bus.b_valid  = bvalid;

  // read channel out, single beat incr word
  assign arid    = axi_bus.ar_id;
  assign araddr  = axi_bus.ar_addr;
  assign arlen   = 8'd0;
  assign arsize  = axi_size_word;
  assign arburst = axi_burst_incr;
  assign arlock  = axi_lock_normal;
  assign arcache = axi_cache_none;
  assign arprot  = axi_prot_data;
  assign arvalid = axi_bus.ar_valid;
  assign rready  = axi_bus.r_ready;

  // write channels out
  assign awid    = axi_bus.aw_id;
  assign awaddr  = axi_bus.aw_addr;
  assign awlen   = 8'd0;
  assign awsize  = axi_size_word;
  assign awburst = axi_burst_incr;
  assign awlock  = axi_lock_normal;
  assign awcache = axi_cache_none;
  assign awprot  = axi_prot_data;
  assign awvalid = axi_bus.aw_valid;
  // axi3 wid mirrors awid
  assign wid     = axi_bus.aw_id;
  assign wdata   = axi_bus.w_data;
  assign wstrb   = axi_bus.w_strb;
  assign wlast   = 1'b1;
  assign wvalid  = axi_bus.w_valid;
  assign bready  = axi_bus.b_ready;

  core_exec u_core_exec (
    .aclk        (aclk),
    .reset       (reset_q),
    .mem         (mem_req),
    .trace_wen   (debug0_wb_rf_wen),
    .trace_pc    (debug0_wb_pc),
    .trace_inst  (debug0_wb_inst),
    .trace_wdata (debug0_wb_rf_wdata),
    .trace_wnum  (debug0_wb_rf_wnum)
  );

  axi_master u_axi_master (
    .aclk  (aclk),
    .reset (reset_q),
    .req   (mem_req),
    .axi   (axi_bus)
  );

endmodule

/* source/axi_master.sv */
`timescale 1ns/1ps

module axi_master (
  input logic          aclk,
  input logic          reset,
  mem_req_if.responder req,
  la_axi_bus.master    axi
);
  import core_pkg::*;

  logic [1:0]          state;
  // latched request fields
  logic [axi_id_w-1:0] cur_id;
  logic [xlen-1:0]     cur_addr;
  logic [xlen-1:0]     cur_wdata;

  assign axi.ar_id   = cur_id;
  assign axi.ar_addr = cur_addr;
  assign axi.aw_id   = cur_id;
  assign axi.aw_addr = cur_addr;
  assign axi.w_data  = cur_wdata;
  // full word writes only
  assign axi.w_strb  = 4'hf;

  always_ff @(posedge aclk) begin
    if (reset) begin
      state        <= mst_idle;
      axi.ar_valid <= 1'b0;
      axi.aw_valid <= 1'b0;
      axi.w_valid  <= 1'b0;
      axi.r_ready  <= 1'b0;
      axi.b_ready  <= 1'b0;
      req.done     <= 1'b0;
    end else begin
      req.done <= 1'b0;
      case (state)
        mst_idle: begin
          if (req.req && req.write) begin
            axi.aw_valid <= 1'b1;
            axi.w_valid  <= 1'b1;
            state        <= mst_write;
          end else if (req.req) begin
            axi.ar_valid <= 1'b1;
            state        <= mst_read;
          end
        end
        mst_read: begin
          if (axi.ar_ready) begin
            axi.ar_valid <= 1'b0;
            axi.r_ready  <= 1'b1;
            state        <= mst_resp;
          end
        end
        mst_write: begin
          // aw and w accepted independently
          if (axi.aw_ready) begin
            axi.aw_valid <= 1'b0;
          end
          if (axi.w_ready) begin
            axi.w_valid <= 1'b0;
          end
          if ((axi.aw_ready || !axi.aw_valid) && (axi.w_ready || !axi.w_valid)) begin
            axi.b_ready <= 1'b1;
            state       <= mst_resp;
          end
        end
        mst_resp: begin
          // only one of r_ready / b_ready is up here
          if (axi.r_valid && axi.r_ready) begin
            axi.r_ready <= 1'b0;
            req.done    <= 1'b1;
            state       <= mst_idle;
          end
          if (axi.b_valid && axi.b_ready) begin
            axi.b_ready <= 1'b0;
            req.done    <= 1'b1;
            state       <= mst_idle;
          end
        end
        default: begin
          state <= mst_idle;
        end
      endcase
    end
  end

  // payload, captured on request and on read data
  always_ff @(posedge aclk) begin
    if (state == mst_idle && req.req) begin
      cur_id    <= req.fetch ? axi_id_fetch : axi_id_data;
      cur_addr  <= req.addr;
      cur_wdata <= req.wdata;
    end
    if (axi.r_valid && axi.r_ready) begin
      req.rdata <= axi.r_data;
    end
  end

  // error responses are not retried, only flagged
  assert property (@(posedge aclk) disable iff (reset)
    axi.r_valid && axi.r_ready |->
      axi.r_resp == resp_okay && axi.r_last && axi.r_id == cur_id);

  assert property (@(posedge aclk) disable iff (reset)
    axi.b_valid && axi.b_ready |-> axi.b_resp == resp_okay && axi.b_id == cur_id);

  // ar held with a stable address until accepted
  assert property (@(posedge aclk) disable iff (reset)
    axi.ar_valid && !axi.ar_ready |=> axi.ar_valid && $stable(axi.ar_addr));

endmodule

/* source/core_exec.sv */
`timescale 1ns/1ps

module core_exec (
  input  logic                      aclk,
  input  logic                      reset,
  mem_req_if.requester              mem,
  output logic [3:0]                trace_wen,
  output logic [core_pkg::xlen-1:0] trace_pc,
  output logic [core_pkg::xlen-1:0] trace_inst,
  output logic [core_pkg::xlen-1:0] trace_wdata,
  output logic [4:0]                trace_wnum
);
  import core_pkg::*;

  logic [2:0]      state;
  logic [xlen-1:0] pc;
  // fetched word decoded through both views
  inst_t           inst_q;
  logic [xlen-1:0] result_q;
  logic            wb_en_q;
  // set while a bus request is open
  logic            req_open;

  logic            is_addi;
  logic            is_add;
  logic            is_ld;
  logic            is_st;
  logic            is_mem;
  logic [xlen-1:0] imm_ext;
  logic [4:0]      rf_ra2;
  logic [xlen-1:0] rf_rd1;
  logic [xlen-1:0] rf_rd2;
  logic [xlen-1:0] alu_out;
  logic            rf_we;

  // decode
  assign is_addi = inst_q.ri12.opcode == op_addi_w;
  assign is_ld   = inst_q.ri12.opcode == op_ld_w;
  assign is_st   = inst_q.ri12.opcode == op_st_w;
  assign is_add  = inst_q.r3.opcode == op_add_w;
  assign is_mem  = is_ld || is_st;
  assign imm_ext = {{(xlen - 12){inst_q.ri12.imm[11]}}, inst_q.ri12.imm};

  // second read port is rk for 3R, store data (rd) otherwise
  assign rf_ra2 = is_add ? inst_q.r3.rk : inst_q.ri12.rd;

  reg_file u_reg_file (
    .aclk (aclk),
    .ra1  (inst_q.ri12.rj),
    .ra2  (rf_ra2),
    .wa   (inst_q.ri12.rd),
    .we   (rf_we),
    .wd   (result_q),
    .rd1  (rf_rd1),
    .rd2  (rf_rd2)
  );

  // add.w uses rk, everything else rj + imm (incl. ld/st address)
  assign alu_out = is_add ? rf_rd1 + rf_rd2 : rf_rd1 + imm_ext;

  // bus request pulses on entry to a wait state
  assign mem.req   = (state == st_fetch) || (state == st_exec && is_mem);
  assign mem.fetch = (state == st_fetch) || (state == st_fetch_wait);
  assign mem.write = !mem.fetch && is_st;
  assign mem.addr  = mem.fetch ? pc : alu_out;
  assign mem.wdata = rf_rd2;

  always_ff @(posedge aclk) begin
    if (reset) begin
      state   <= st_fetch;
      pc      <= reset_pc;
      wb_en_q <= 1'b0;
    end else begin
      case (state)
        st_fetch: begin
          state <= st_fetch_wait;
        end
        st_fetch_wait: begin
          if (mem.done) begin
            state <= st_exec;
          end
        end
        st_exec: begin
          // writes to r0 are dropped here with no trace
          wb_en_q <= (is_addi || is_add || is_ld) && inst_q.ri12.rd != 5'd0;
          state   <= is_mem ? st_mem_wait : st_wb;
        end
        st_mem_wait: begin
          if (mem.done) begin
            state <= st_wb;
          end
        end
        st_wb: begin
          // unknown opcodes retire here as no-ops
          pc    <= pc + 32'd4;
          state <= st_fetch;
        end
        default: begin
          state <= st_fetch;
        end
      endcase
    end
  end

  // instruction word and result
  always_ff @(posedge aclk) begin
    if (state == st_fetch_wait && mem.done) begin
      inst_q <= mem.rdata;
    end
    if (state == st_exec) begin
      result_q <= alu_out;
    end else if (state == st_mem_wait && mem.done && is_ld) begin
      result_q <= mem.rdata;
    end
  end

  always_ff @(posedge aclk) begin
    if (reset) begin
      req_open <= 1'b0;
    end else if (mem.req) begin
      req_open <= 1'b1;
    end else if (mem.done) begin
      req_open <= 1'b0;
    end
  end

  // writeback and trace
  assign rf_we       = (state == st_wb) && wb_en_q;
  assign trace_wen   = rf_we ? 4'hf : 4'h0;
  assign trace_pc    = pc;
  assign trace_inst  = inst_q;
  assign trace_wnum  = inst_q.ri12.rd;
  assign trace_wdata = result_q;

  // no register write while a fetch or memory request is still open
  assert property (@(posedge aclk) disable iff (reset) rf_we |-> !req_open);

  // only one bus request open at a time
  assert property (@(posedge aclk) disable iff (reset) mem.req |-> !req_open);

endmodule

/* source/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
  input  logic                     aclk,
  input  logic [4:0]               ra1,
  input  logic [4:0]               ra2,
  input  logic [4:0]               wa,
  input  logic                     we,
  input  logic [core_pkg::xlen-1:0] wd,
  output logic [core_pkg::xlen-1:0] rd1,
  output logic [core_pkg::xlen-1:0] rd2
);
  import core_pkg::*;

  // general registers, entry 0 is never written
  logic [xlen-1:0] regs [32];

  always_ff @(posedge aclk) begin
    if (we && wa != 5'd0) begin
      regs[wa] <= wd;
    end
  end

  // async reads, r0 forced to zero
  assign rd1 = (ra1 == 5'd0) ? '0 : regs[ra1];
  assign rd2 = (ra2 == 5'd0) ? '0 : regs[ra2];

  // write address must be resolved whenever a write is enabled
  assert property (@(posedge aclk) we |-> !$isunknown(wa));

endmodule

/* source/mem_req_if.sv */
`timescale 1ns/1ps

interface mem_req_if;
  import core_pkg::*;

  // one-cycle request pulse, fields held until done
  logic            req;
  logic            write;
  // selects the fetch id on the bus
  logic            fetch;
  logic [xlen-1:0] addr;
  logic [xlen-1:0] wdata;
  // one-cycle completion, rdata valid with it
  logic            done;
  logic [xlen-1:0] rdata;

  modport requester (
    output req, write, fetch, addr, wdata,
    input  done, rdata
  );

  modport responder (
    input  req, write, fetch, addr, wdata,
    output done, rdata
  );

endinterface

/* source/la_axi_bus.sv */
`timescale 1ns/1ps

interface la_axi_bus;
  import core_pkg::*;

  // read address
  logic [axi_id_w-1:0] ar_id;
  logic [xlen-1:0]     ar_addr;
  logic                ar_valid;
  logic                ar_ready;
  // read data, always a single beat
  logic [axi_id_w-1:0] r_id;
  logic [xlen-1:0]     r_data;
  logic [1:0]          r_resp;
  logic                r_last;
  logic                r_valid;
  logic                r_ready;
  // write address
  logic [axi_id_w-1:0] aw_id;
  logic [xlen-1:0]     aw_addr;
  logic                aw_valid;
  logic                aw_ready;
  // write data, wid and wlast come from the top level
  logic [xlen-1:0]     w_data;
  logic [3:0]          w_strb;
  logic                w_valid;
  logic                w_ready;
  // write response
  logic [axi_id_w-1:0] b_id;
  logic [1:0]          b_resp;
  logic                b_valid;
  logic                b_ready;

  modport master (
    output ar_id, ar_addr, ar_valid, r_ready,
    output aw_id, aw_addr, aw_valid, w_data, w_strb, w_valid, b_ready,
    input  ar_ready, r_id, r_data, r_resp, r_last, r_valid,
    input  aw_ready, w_ready, b_id, b_resp, b_valid
  );

  modport slave (
    input  ar_id, ar_addr, ar_valid, r_ready,
    input  aw_id, aw_addr, aw_valid, w_data, w_strb, w_valid, b_ready,
    output ar_ready, r_id, r_data, r_resp, r_last, r_valid,
    output aw_ready, w_ready, b_id, b_resp, b_valid
  );

endinterface

/* source/core_pkg.sv */
package core_pkg;

  // datapath and address width
  localparam int xlen = 32;
  // first fetch address after reset
  localparam logic [xlen-1:0] reset_pc = 32'h1c00_0000;

  // 2RI12 opcodes, inst[31:22]
  localparam logic [9:0] op_addi_w = 10'h00a;
  localparam logic [9:0] op_ld_w   = 10'h0a2;
  localparam logic [9:0] op_st_w   = 10'h0a6;
  // 3R opcode, inst[31:15]
  localparam logic [16:0] op_add_w = 17'h00020;

  // one instruction word, two decode views
  typedef union packed {
    struct packed {
      logic [9:0]         opcode;
      logic signed [11:0] imm;
      logic [4:0]         rj;
      logic [4:0]         rd;
    } ri12;
    struct packed {
      logic [16:0] opcode;
      logic [4:0]  rk;
      logic [4:0]  rj;
      logic [4:0]  rd;
    } r3;
  } inst_t;

  // fixed axi attributes
  localparam int axi_id_w = 4;
  localparam logic [axi_id_w-1:0] axi_id_fetch = 4'd0;
  localparam logic [axi_id_w-1:0] axi_id_data  = 4'd1;
  localparam logic [2:0] axi_size_word   = 3'd2;
  localparam logic [1:0] axi_burst_incr  = 2'd1;
  localparam logic [1:0] axi_lock_normal = 2'd0;
  localparam logic [3:0] axi_cache_none  = 4'd0;
  localparam logic [2:0] axi_prot_data   = 3'd0;
  localparam logic [1:0] resp_okay       = 2'd0;

  // core fsm states
  localparam logic [2:0] st_fetch      = 3'd0;
  localparam logic [2:0] st_fetch_wait = 3'd1;
  localparam logic [2:0] st_exec       = 3'd2;
  localparam logic [2:0] st_mem_wait   = 3'd3;
  localparam logic [2:0] st_wb         = 3'd4;

  // bus master fsm states
  localparam logic [1:0] mst_idle  = 2'd0;
  localparam logic [1:0] mst_read  = 2'd1;
  localparam logic [1:0] mst_write = 2'd2;
  localparam logic [1:0] mst_resp  = 2'd3;

endpackage
